// File: common/mdu_config.svh
`ifndef MDU_CONFIG_SVH
`define MDU_CONFIG_SVH

// operand and result width.
`define MDU_XLEN 32

// destination register index width.
`define MDU_RD_W 5

// number of multiplier pipeline stages.
`define MDU_MUL_STAGES 2

`endif

// File: common/mdu_pkg.sv
`default_nettype none

`include "mdu_config.svh"

package mdu_pkg;

    //////////////////////////////////////////////////
    // opcodes and states
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } md_op_e;

    typedef enum logic [2:0] {
        D_IDLE,
        D_INIT,
        D_CALC,
        D_SIGN,
        D_DONE
    } div_state_e;

    //////////////////////////////////////////////////
    // request and response structs
    //////////////////////////////////////////////////

    typedef struct packed {
        md_op_e                op;
        logic [`MDU_RD_W-1:0]  rd;
        logic [`MDU_XLEN-1:0]  rs1;
        logic [`MDU_XLEN-1:0]  rs2;
    } md_req_t;

    typedef struct packed {
        logic [`MDU_RD_W-1:0]  rd;
        logic [`MDU_XLEN-1:0]  result;
    } md_rsp_t;

    typedef struct packed {
        logic [`MDU_XLEN-1:0]  a;
        logic [`MDU_XLEN-1:0]  b;
        logic                  a_signed;
        logic                  b_signed;
        logic                  high;      // select upper product word.
        logic [`MDU_RD_W-1:0]  rd;
    } mul_req_t;

    typedef struct packed {
        logic [`MDU_XLEN-1:0]  a;
        logic [`MDU_XLEN-1:0]  b;
        logic                  is_signed;
        logic                  want_rem;  // remainder instead of quotient.
        logic [`MDU_RD_W-1:0]  rd;
    } div_req_t;

endpackage

`default_nettype wire

// File: design/mdu_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module mdu_issue
    import mdu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     req_valid_i,
    input  md_req_t  req_i,
    output logic     req_ready_o,
    input  logic     mul_ready_i,
    input  logic     div_ready_i,
    input  logic     div_busy_i,
    input  logic     mul_done_i,
    output logic     mul_valid_o,
    output mul_req_t mul_req_o,
    output logic     div_valid_o,
    output div_req_t div_req_o
);

    localparam int CNT_W = $clog2(`MDU_MUL_STAGES + 1);

    logic             is_div;
    logic             mul_accept;
    logic             mul_idle;
    logic [CNT_W-1:0] mul_inflight;

    //////////////////////////////////////////////////
    // opcode decode
    //////////////////////////////////////////////////

    always_comb begin
        is_div             = 1'b0;
        mul_req_o.a        = req_i.rs1;
        mul_req_o.b        = req_i.rs2;
        mul_req_o.a_signed = 1'b0;
        mul_req_o.b_signed = 1'b0;
        mul_req_o.high     = 1'b1;
        mul_req_o.rd       = req_i.rd;
        div_req_o.a        = req_i.rs1;
        div_req_o.b        = req_i.rs2;
        div_req_o.is_signed = 1'b0;
        div_req_o.want_rem = 1'b0;
        div_req_o.rd       = req_i.rd;
        case (req_i.op)
            MUL:    mul_req_o.high = 1'b0;  // low word is sign agnostic.
            MULH: begin
                mul_req_o.a_signed = 1'b1;
                mul_req_o.b_signed = 1'b1;
            end
            MULHSU: mul_req_o.a_signed = 1'b1;
            MULHU:  mul_req_o.high = 1'b1;
            DIV: begin
                is_div              = 1'b1;
                div_req_o.is_signed = 1'b1;
            end
            DIVU:   is_div = 1'b1;
            REM: begin
                is_div              = 1'b1;
                div_req_o.is_signed = 1'b1;
                div_req_o.want_rem  = 1'b1;
            end
            REMU: begin
                is_div             = 1'b1;
                div_req_o.want_rem = 1'b1;
            end
            default: is_div = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // routing and ordering
    //////////////////////////////////////////////////

    assign mul_idle    = (mul_inflight == '0);
    assign mul_valid_o = req_valid_i && !is_div && !div_busy_i;
    assign div_valid_o = req_valid_i && is_div && !div_busy_i && mul_idle;
    assign mul_accept  = mul_valid_o && mul_ready_i;

    // a divide waits until every multiply has reached the response register.
    assign req_ready_o = !div_busy_i &&
                         (is_div ? (mul_idle && div_ready_i) : mul_ready_i);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mul_inflight <= '0;
        end else if (mul_accept && !mul_done_i) begin
            mul_inflight <= mul_inflight + 1'b1;  // one more in the pipe.
        end else if (!mul_accept && mul_done_i) begin
            mul_inflight <= mul_inflight - 1'b1;  // retired into merge.
        end
    end

endmodule

`default_nettype wire

// File: multiplier/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module mul_unit
    import mdu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     valid_i,
    input  mul_req_t req_i,
    output logic     ready_o,
    input  logic     take_i,
    output logic     valid_o,
    output md_rsp_t  rsp_o
);

    localparam int W = `MDU_XLEN;

    logic signed [W:0]     a_ext;
    logic signed [W:0]     b_ext;

    // stage one.
    logic                  s1_valid;
    logic signed [2*W+1:0] s1_prod;
    logic                  s1_high;
    logic [`MDU_RD_W-1:0]  s1_rd;

    // stage two.
    logic                  s2_valid;
    md_rsp_t               s2_rsp;
    logic                  s2_adv;

    //////////////////////////////////////////////////
    // flow control
    //////////////////////////////////////////////////

    assign s2_adv  = !s2_valid || take_i;   // stage two can load.
    assign ready_o = !s1_valid || s2_adv;   // stage one can load.

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (ready_o) begin
                s1_valid <= valid_i;
            end
            if (s2_adv) begin
                s2_valid <= s1_valid;
            end
        end
    end

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////

    // one extra bit lets a single signed multiply cover all three sign modes.
    assign a_ext = {req_i.a_signed & req_i.a[W-1], req_i.a};
    assign b_ext = {req_i.b_signed & req_i.b[W-1], req_i.b};

    always_ff @(posedge clk) begin
        if (ready_o && valid_i) begin
            s1_prod <= a_ext * b_ext;
            s1_high <= req_i.high;
            s1_rd   <= req_i.rd;
        end
        if (s2_adv && s1_valid) begin
            s2_rsp.rd     <= s1_rd;
            s2_rsp.result <= s1_high ? s1_prod[2*W-1:W]  // upper word.
                                     : s1_prod[W-1:0];   // lower word.
        end
    end

    assign valid_o = s2_valid;
    assign rsp_o   = s2_rsp;

endmodule

`default_nettype wire

// File: divider/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module div_unit
    import mdu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     valid_i,
    input  div_req_t req_i,
    output logic     ready_o,
    output logic     busy_o,
    input  logic     take_i,
    output logic     valid_o,
    output md_rsp_t  rsp_o
);

    localparam int N = `MDU_XLEN;

    div_state_e           state;
    logic [$clog2(N)-1:0] count;

    logic                 start;
    logic                 sign_a;
    logic                 sign_b;
    logic                 div_zero;
    logic                 div_one;
    logic                 overflow;
    logic                 special;
    logic [N-1:0]         special_res;

    logic [N-1:0]         a_mag;
    logic [N-1:0]         b_mag;
    logic                 neg_q;
    logic                 neg_r;
    logic                 want_rem;
    logic [`MDU_RD_W-1:0] rd_q;

    logic [N-1:0]         acc;
    logic [N-1:0]         quo;
    logic [N:0]           trial;
    logic [N:0]           diff;
    logic [N-1:0]         next_acc;
    logic [N-1:0]         next_quo;
    logic [N-1:0]         result;

    //////////////////////////////////////////////////
    // request decode
    //////////////////////////////////////////////////

    assign start    = valid_i && (state == D_IDLE);
    assign sign_a   = req_i.is_signed & req_i.a[N-1];
    assign sign_b   = req_i.is_signed & req_i.b[N-1];
    assign div_zero = (req_i.b == '0);
    assign div_one  = (req_i.b == N'(1));
    assign overflow = req_i.is_signed && (req_i.b == '1) &&
                      (req_i.a == {1'b1, {(N-1){1'b0}}});
    assign special  = div_zero || div_one || overflow;

    always_comb begin
        if (div_zero) begin
            special_res = req_i.want_rem ? req_i.a : '1;
        end else begin
            special_res = req_i.want_rem ? '0 : req_i.a;  // divide by one or overflow.
        end
    end

    //////////////////////////////////////////////////
    // restoring step
    //////////////////////////////////////////////////

    always_comb begin
        trial = {acc, quo[N-1]};
        diff  = trial - {1'b0, b_mag};
        if (!diff[N]) begin
            next_acc = diff[N-1:0];                // subtract fits.
            next_quo = {quo[N-2:0], 1'b1};
        end else begin
            next_acc = trial[N-1:0];               // restore.
            next_quo = {quo[N-2:0], 1'b0};
        end
    end

    //////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= D_IDLE;
            count <= '0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (start) begin
                        state <= special ? D_DONE : D_INIT;
                    end
                end
                D_INIT: begin
                    state <= D_CALC;
                    count <= '0;
                end
                D_CALC: begin
                    count <= count + 1'b1;
                    if (count == N - 1) begin
                        state <= D_SIGN;
                    end
                end
                D_SIGN:  state <= D_DONE;
                D_DONE: begin
                    if (take_i) begin
                        state <= D_IDLE;  // result handed to merge.
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        case (state)
            D_IDLE: begin
                if (start) begin
                    a_mag    <= sign_a ? -req_i.a : req_i.a;
                    b_mag    <= sign_b ? -req_i.b : req_i.b;
                    neg_q    <= sign_a ^ sign_b;
                    neg_r    <= sign_a;  // remainder follows the dividend.
                    want_rem <= req_i.want_rem;
                    rd_q     <= req_i.rd;
                    result   <= special_res;
                end
            end
            D_INIT: begin
                acc <= '0;
                quo <= a_mag;  // dividend shifts out as quotient shifts in.
            end
            D_CALC: begin
                acc <= next_acc;
                quo <= next_quo;
            end
            D_SIGN: begin
                if (want_rem) begin
                    result <= neg_r ? -acc : acc;
                end else begin
                    result <= neg_q ? -quo : quo;
                end
            end
            default: result <= result;
        endcase
    end

    assign ready_o      = (state == D_IDLE);
    assign busy_o       = (state != D_IDLE);
    assign valid_o      = (state == D_DONE);
    assign rsp_o.rd     = rd_q;
    assign rsp_o.result = result;

endmodule

`default_nettype wire

// File: design/mdu_result_merge.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_result_merge
    import mdu_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    mul_valid_i,
    input  md_rsp_t mul_rsp_i,
    input  logic    div_valid_i,
    input  md_rsp_t div_rsp_i,
    output logic    mul_take_o,
    output logic    div_take_o,
    output logic    mul_done_o,
    output logic    rsp_valid_o,
    input  logic    rsp_ready_i,
    output md_rsp_t rsp_o
);

    logic    load;
    logic    rsp_valid_q;
    md_rsp_t rsp_q;

    //////////////////////////////////////////////////
    // load control
    //////////////////////////////////////////////////

    // empty, or emptied by the consumer this cycle.
    assign load = !rsp_valid_q || rsp_ready_i;

    // issue ordering keeps both engines from being valid at once.
    assign mul_take_o = load && mul_valid_i;
    assign div_take_o = load && div_valid_i && !mul_valid_i;

    // lets issue retire the multiply from its in-flight count.
    assign mul_done_o = mul_take_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rsp_valid_q <= 1'b0;
        end else if (load) begin
            rsp_valid_q <= mul_valid_i || div_valid_i;
        end
    end

    //////////////////////////////////////////////////
    // response register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (mul_take_o) begin
            rsp_q <= mul_rsp_i;
        end else if (div_take_o) begin
            rsp_q <= div_rsp_i;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// File: design/mdu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_top
    import mdu_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    req_valid_i,
    output logic    req_ready_o,
    input  md_req_t req_i,
    output logic    rsp_valid_o,
    input  logic    rsp_ready_i,
    output md_rsp_t rsp_o
);

    // issue to engines.
    logic     mul_valid;
    logic     mul_ready;
    mul_req_t mul_req;
    logic     div_valid;
    logic     div_ready;
    logic     div_busy;
    div_req_t div_req;

    // engines to merge.
    logic     mul_rsp_valid;
    md_rsp_t  mul_rsp;
    logic     div_rsp_valid;
    md_rsp_t  div_rsp;
    logic     mul_take;
    logic     div_take;
    logic     mul_done;

    mdu_issue u_issue (
        .clk         (clk),
        .reset_n     (reset_n),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .mul_ready_i (mul_ready),
        .div_ready_i (div_ready),
        .div_busy_i  (div_busy),
        .mul_done_i  (mul_done),
        .mul_valid_o (mul_valid),
        .mul_req_o   (mul_req),
        .div_valid_o (div_valid),
        .div_req_o   (div_req)
    );

    mul_unit u_mul (
        .clk     (clk),
        .reset_n (reset_n),
        .valid_i (mul_valid),
        .req_i   (mul_req),
        .ready_o (mul_ready),
        .take_i  (mul_take),
        .valid_o (mul_rsp_valid),
        .rsp_o   (mul_rsp)
    );

    div_unit u_div (
        .clk     (clk),
        .reset_n (reset_n),
        .valid_i (div_valid),
        .req_i   (div_req),
        .ready_o (div_ready),
        .busy_o  (div_busy),
        .take_i  (div_take),
        .valid_o (div_rsp_valid),
        .rsp_o   (div_rsp)
    );

    mdu_result_merge u_merge (
        .clk         (clk),
        .reset_n     (reset_n),
        .mul_valid_i (mul_rsp_valid),
        .mul_rsp_i   (mul_rsp),
        .div_valid_i (div_rsp_valid),
        .div_rsp_i   (div_rsp),
        .mul_take_o  (mul_take),
        .div_take_o  (div_take),
        .mul_done_o  (mul_done),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

endmodule

`default_nettype wire

// File: tests/mdu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module mdu_checker
    import mdu_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    req_valid_i,
    input  logic    req_ready_i,
    input  md_req_t req_i,
    input  logic    rsp_valid_i,
    input  logic    rsp_ready_i,
    input  md_rsp_t rsp_i,
    output int      error_count_o,
    output int      req_count_o,
    output int      rsp_count_o,
    output int      pending_o
);

    localparam int W = `MDU_XLEN;

    md_rsp_t exp_q[$];
    md_rsp_t exp_rsp;
    md_rsp_t held_rsp;
    logic    stalled = 1'b0;   // response was refused on the last edge.
    int      errors  = 0;
    int      n_req   = 0;
    int      n_rsp   = 0;
    int      pending = 0;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic logic [W-1:0] expected_result(
        input md_op_e       op,
        input logic [W-1:0] a,
        input logic [W-1:0] b
    );
        logic [2*W-1:0]      a_sx;
        logic [2*W-1:0]      b_sx;
        logic [2*W-1:0]      a_zx;
        logic [2*W-1:0]      b_zx;
        logic [2*W-1:0]      p_ss;
        logic [2*W-1:0]      p_su;
        logic [2*W-1:0]      p_uu;
        logic signed [W-1:0] sa;
        logic signed [W-1:0] sb;
        logic signed [W-1:0] sq;
        logic signed [W-1:0] sr;
        logic [W-1:0]        uq;
        logic [W-1:0]        ur;
        logic                ovf;
        logic [W-1:0]        res;
        a_sx = {{W{a[W-1]}}, a};
        b_sx = {{W{b[W-1]}}, b};
        a_zx = {{W{1'b0}}, a};
        b_zx = {{W{1'b0}}, b};
        p_ss = a_sx * b_sx;      // products modulo 2^(2W).
        p_su = a_sx * b_zx;
        p_uu = a_zx * b_zx;
        sa   = a;
        sb   = b;
        ovf  = (a == {1'b1, {(W-1){1'b0}}}) && (b == '1);
        sq   = '1;               // divide by zero.
        sr   = a;
        uq   = '1;
        ur   = a;
        if (b != '0) begin
            uq = a / b;
            ur = a % b;
            if (ovf) begin
                sq = a;
                sr = '0;
            end else begin
                sq = sa / sb;    // truncates toward zero.
                sr = sa % sb;    // sign of the dividend.
            end
        end
        case (op)
            MUL:     res = p_uu[W-1:0];
            MULH:    res = p_ss[2*W-1:W];
            MULHSU:  res = p_su[2*W-1:W];
            MULHU:   res = p_uu[2*W-1:W];
            DIV:     res = sq;
            DIVU:    res = uq;
            REM:     res = sr;
            default: res = ur;
        endcase
        return res;
    endfunction

    //////////////////////////////////////////////////
    // scoreboard
    //////////////////////////////////////////////////

    // a handshake seen at the falling edge completes on the next rise.
    always @(negedge clk) begin
        if (!reset_n) begin
            stalled = 1'b0;
        end else begin
            if (req_valid_i && req_ready_i) begin
                exp_rsp.rd     = req_i.rd;
                exp_rsp.result = expected_result(req_i.op, req_i.rs1, req_i.rs2);
                exp_q.push_back(exp_rsp);
                n_req++;
            end
            if (stalled && (!rsp_valid_i || rsp_i !== held_rsp)) begin
                errors++;
                $display("** Error at time %0t: response dropped or changed while stalled",
                         $time);
            end
            if (rsp_valid_i && rsp_ready_i) begin
                n_rsp++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("** Error at time %0t: response rd=%0d result=%h without request",
                             $time, rsp_i.rd, rsp_i.result);
                end else begin
                    exp_rsp = exp_q.pop_front();
                    if (rsp_i !== exp_rsp) begin
                        errors++;
                        $display("** Error at time %0t: got rd=%0d result=%h, expected rd=%0d %h",
                                 $time, rsp_i.rd, rsp_i.result, exp_rsp.rd, exp_rsp.result);
                    end
                end
            end
            stalled  = rsp_valid_i && !rsp_ready_i;
            held_rsp = rsp_i;
            pending  = exp_q.size();
        end
    end

    assign error_count_o = errors;
    assign req_count_o   = n_req;
    assign rsp_count_o   = n_rsp;
    assign pending_o     = pending;

endmodule

`default_nettype wire

// File: tests/tb_mdu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module tb_mdu
    import mdu_pkg::*;
();

    localparam int          W             = `MDU_XLEN;
    localparam int          CLK_PERIOD    = 4;
    localparam int          REQ_TIMEOUT   = 500;
    localparam int          DRAIN_TIMEOUT = 2000;
    localparam int          N_RANDOM      = 600;
    localparam logic [31:0] SEED          = 32'ha082_5ae4;

    logic    clk;
    logic    reset_n;
    logic    req_valid_i;
    logic    req_ready_o;
    md_req_t req_i;
    logic    rsp_valid_o;
    logic    rsp_ready_i;
    md_rsp_t rsp_o;

    int      seed;
    logic    bp_on;          // random stalls on the response port.
    logic    timed_out;
    int      other_errors;
    int      error_count;
    int      req_count;
    int      rsp_count;
    int      pending;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    mdu_top DUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

    mdu_checker u_checker (
        .clk           (clk),
        .reset_n       (reset_n),
        .req_valid_i   (req_valid_i),
        .req_ready_i   (req_ready_o),
        .req_i         (req_i),
        .rsp_valid_i   (rsp_valid_o),
        .rsp_ready_i   (rsp_ready_i),
        .rsp_i         (rsp_o),
        .error_count_o (error_count),
        .req_count_o   (req_count),
        .rsp_count_o   (rsp_count),
        .pending_o     (pending)
    );

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    function automatic logic [W-1:0] corner_value(input int idx);
        case (idx)
            0:       return '0;
            1:       return W'(1);
            2:       return '1;                          // minus one.
            3:       return {1'b1, {(W-1){1'b0}}};       // most negative.
            4:       return {1'b0, {(W-1){1'b1}}};       // most positive.
            5:       return W'(7);
            6:       return -W'(7);
            7:       return W'(3);
            8:       return -W'(3);
            9:       return W'(2);
            10:      return {1'b1, {(W-2){1'b0}}, 1'b1};
            11:      return W'(65536);
            default: return {(W/2){2'b10}};
        endcase
    endfunction

    // advance one rising edge and pick a new response stall.
    task automatic next_cycle();
        @(posedge clk);
        if (bp_on) begin
            rsp_ready_i <= ($random(seed) & 3) != 0;
        end else begin
            rsp_ready_i <= 1'b1;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic send(input md_op_e op, input logic [W-1:0] a, input logic [W-1:0] b);
        logic [31:0] r;
        int          waited;
        logic        accepted;
        r        = $random(seed);
        waited   = 0;
        accepted = 1'b0;
        req_valid_i <= !timed_out;
        req_i       <= '{op: op, rd: r[`MDU_RD_W-1:0], rs1: a, rs2: b};
        while (!accepted && !timed_out) begin
            @(negedge clk);
            accepted = req_ready_o;  // transfer on the coming edge.
            next_cycle();
            waited++;
            if (!accepted && waited >= REQ_TIMEOUT) begin
                $display("timeout: %s request not accepted within %0d cycles",
                         op.name(), REQ_TIMEOUT);
                timed_out = 1'b1;
            end
        end
        req_valid_i <= 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending != 0 && !timed_out) begin
            next_cycle();
            waited++;
            if (waited >= DRAIN_TIMEOUT) begin
                $display("timeout: %0d responses still outstanding after %0d cycles",
                         pending, DRAIN_TIMEOUT);
                timed_out = 1'b1;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0]  r;
        logic [W-1:0] a;
        logic [W-1:0] b;
        seed         = SEED;
        bp_on        = 1'b0;
        timed_out    = 1'b0;
        other_errors = 0;
        reset_n      = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        rsp_ready_i  = 1'b1;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        @(negedge clk);
        if (rsp_valid_o !== 1'b0 || req_ready_o !== 1'b1) begin
            other_errors++;
            $display("** Error at time %0t: after reset rsp_valid_o=%b req_ready_o=%b",
                     $time, rsp_valid_o, req_ready_o);
        end
        next_cycle();

        // multiplies back to back on every pair of corner operands.
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < 12; i++) begin
                for (int j = 0; j < 12; j++) begin
                    send(md_op_e'(op[2:0]), corner_value(i), corner_value(j));
                end
            end
        end

        // divides on every sign pairing and the three shortcut cases.
        bp_on = 1'b1;
        for (int op = 4; op < 8; op++) begin
            for (int i = 0; i < 12; i++) begin
                for (int j = 0; j < 12; j++) begin
                    send(md_op_e'(op[2:0]), corner_value(i), corner_value(j));
                end
            end
        end

        // random mix with corner operands now and then.
        for (int n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            a = $random(seed);
            b = $random(seed);
            if (r[4:3] == 2'b00) begin
                a = corner_value(int'(r[8:5]));
            end
            if (r[10:9] == 2'b00) begin
                b = corner_value(int'(r[14:11]));
            end
            send(md_op_e'(r[2:0]), a, b);
            if (r[16:15] == 2'b00) begin
                idle(1);
            end
        end

        drain();
        bp_on = 1'b0;
        idle(4);

        if (req_count != rsp_count || pending != 0) begin
            $display("response count %0d does not match request count %0d",
                     rsp_count, req_count);
        end
        $display("summary: %0d compare errors, %0d other errors, %0d requests, %0d responses",
                 error_count, other_errors, req_count, rsp_count);
        if (timed_out || error_count != 0 || other_errors != 0 ||
            req_count != rsp_count || pending != 0) begin
            $display(">>> FAIL");
        end else begin
            $display(">>> PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+common
common/mdu_pkg.sv
design/mdu_issue.sv
multiplier/mul_unit.sv
divider/div_unit.sv
design/mdu_result_merge.sv
design/mdu_top.sv
tests/mdu_checker.sv
tests/tb_mdu.sv

// File: run_sim.sh
#!/bin/sh
# Build the MDU testbench with Verilator, run it and look for the pass line.
# Lint warnings from Verilator are still printed, they only do not stop the build.

cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_mdu -f flist.f &&
./obj_dir/Vtb_mdu | tee /dev/stderr | grep -x '>>> PASS' > /dev/null &&
echo "run_sim: simulation passed" ||
{
    echo "run_sim: simulation failed"
    exit 1
}
